// File: src/psgPkg.sv
`default_nettype none

package psgPkg;

	// ======================================================================
	// datapath widths
	// ======================================================================
	localparam int sampleWidth  = 8;
	localparam int volWidth     = 7;
	localparam int phaseWidth   = 16;
	localparam int waveAdrWidth = 8;
	localparam int regAdrWidth  = 9;
	localparam int regDataWidth = 16;
	localparam int chanOutWidth = 15;
	localparam int audioWidth   = 16;

	// top phase bits index the wave, 6 bits for a 64 entry window
	localparam int phaseIdxLsb = 10;

	// ======================================================================
	// host register address fields
	// ======================================================================
	localparam int regWaveBit = 8;
	localparam int regChanMsb = 3;
	localparam int regChanLsb = 1;
	localparam int regCfgBit  = 0;

	// one host data word, read as frequency or as configuration
	typedef union packed {
		logic [phaseWidth-1:0] freq;
		struct packed {
			logic                    enable;
			logic [volWidth-1:0]     volume;
			logic [waveAdrWidth-1:0] base;
		} cfg;
	} regWord_u;

endpackage

`default_nettype wire

// File: src/psgRegDecode.sv
`default_nettype none

module psgRegDecode #(
	parameter int numChannels = 8
) (
	input  wire logic                             clk,
	input  wire logic                             rst,
	input  wire logic                             regWr,
	input  wire logic [psgPkg::regAdrWidth-1:0]   regAdr,
	input  wire logic [psgPkg::regDataWidth-1:0]  regData,
	output logic      [numChannels-1:0]           freqWr,
	output logic      [numChannels-1:0]           cfgWr,
	output logic      [psgPkg::phaseWidth-1:0]    freqVal,
	output logic                                  cfgEnable,
	output logic      [psgPkg::volWidth-1:0]      cfgVolume,
	output logic      [psgPkg::waveAdrWidth-1:0]  cfgBase,
	output logic                                  waveWr,
	output logic      [psgPkg::waveAdrWidth-1:0]  waveAdr,
	output logic      [psgPkg::sampleWidth-1:0]   waveData
);

	localparam int chanFieldWidth = psgPkg::regChanMsb - psgPkg::regChanLsb + 1;

	logic                           wrQ;
	logic [psgPkg::regAdrWidth-1:0] adrQ;
	psgPkg::regWord_u               dataQ;
	logic                           isWave;
	logic                           isCfg;
	logic [chanFieldWidth-1:0]      chanField;

	// ======================================================================
	// capture the host write
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			wrQ <= 1'b0;
		end else begin
			wrQ <= regWr;
		end
	end

	always_ff @(posedge clk) begin
		if (regWr) begin
			adrQ  <= regAdr;
			dataQ <= regData;
		end
	end

	// ======================================================================
	// address decode
	// ======================================================================
	assign isWave    = adrQ[psgPkg::regWaveBit];
	assign isCfg     = adrQ[psgPkg::regCfgBit];
	assign chanField = adrQ[psgPkg::regChanMsb:psgPkg::regChanLsb];

	// one strobe per write, channel numbers past numChannels go nowhere
	always_comb begin
		freqWr = '0;
		cfgWr  = '0;
		for (int i = 0; i < numChannels; i++) begin
			if (wrQ && !isWave && chanField == chanFieldWidth'(i)) begin
				if (isCfg) begin
					cfgWr[i] = 1'b1;
				end else begin
					freqWr[i] = 1'b1;
				end
			end
		end
	end

	// both views are broadcast, the strobe says which one counts
	assign freqVal   = dataQ.freq;
	assign cfgEnable = dataQ.cfg.enable;
	assign cfgVolume = dataQ.cfg.volume;
	assign cfgBase   = dataQ.cfg.base;

	// wave memory port, sample sits in the low byte
	assign waveWr   = wrQ & isWave;
	assign waveAdr  = adrQ[psgPkg::waveAdrWidth-1:0];
	assign waveData = dataQ.freq[psgPkg::sampleWidth-1:0];

endmodule

`default_nettype wire

// File: src/psgWaveChannel.sv
`default_nettype none

module psgWaveChannel (
	input  wire logic                                   clk,
	input  wire logic                                   rst,
	input  wire logic                                   ce,
	input  wire logic                                   freqWr,
	input  wire logic                                   cfgWr,
	input  wire logic        [psgPkg::phaseWidth-1:0]   freqVal,
	input  wire logic                                   cfgEnable,
	input  wire logic        [psgPkg::volWidth-1:0]     cfgVolume,
	input  wire logic        [psgPkg::waveAdrWidth-1:0] cfgBase,
	input  wire logic                                   sel,
	input  wire logic                                   ack,
	input  wire logic        [psgPkg::sampleWidth-1:0]  rdData,
	output logic                                        req,
	output logic             [psgPkg::waveAdrWidth-1:0] fetchAdr,
	output logic signed      [psgPkg::chanOutWidth-1:0] chanOut
);

	localparam int idxWidth  = psgPkg::phaseWidth - psgPkg::phaseIdxLsb;
	localparam int prodWidth = psgPkg::sampleWidth + psgPkg::volWidth + 1;

	logic        [psgPkg::phaseWidth-1:0]   freq;
	logic                                   enable;
	logic        [psgPkg::volWidth-1:0]     volume;
	logic        [psgPkg::waveAdrWidth-1:0] base;
	logic        [psgPkg::phaseWidth-1:0]   phase;
	logic signed [psgPkg::sampleWidth-1:0]  sample;
	logic        [psgPkg::waveAdrWidth-1:0] phaseIdx;
	logic signed [prodWidth-1:0]            product;
	logic                                   fetchDone;

	// ======================================================================
	// channel registers
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			freq   <= '0;
			enable <= 1'b0;
			volume <= '0;
			base   <= '0;
		end else begin
			if (freqWr) begin
				freq <= freqVal;
			end
			if (cfgWr) begin
				enable <= cfgEnable;
				volume <= cfgVolume;
				base   <= cfgBase;
			end
		end
	end

	// ======================================================================
	// phase step and fetch request
	// ======================================================================
	assign fetchDone = sel & ack;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase  <= '0;
			req    <= 1'b0;
			sample <= '0;
		end else begin
			if (fetchDone) begin
				req    <= 1'b0;
				sample <= rdData;
			end
			// a new period wins over a late ack
			if (ce && enable) begin
				phase <= phase + freq;
				req   <= 1'b1;
			end
		end
	end

	// address follows the already stepped phase
	assign phaseIdx = {{(psgPkg::waveAdrWidth - idxWidth){1'b0}},
		phase[psgPkg::phaseWidth-1:psgPkg::phaseIdxLsb]};
	assign fetchAdr = base + phaseIdx;

	// ======================================================================
	// volume scaling
	// ======================================================================
	// volume is unsigned, so widen it by a zero before the signed multiply
	assign product = sample * $signed({1'b0, volume});
	assign chanOut = enable ? product[psgPkg::chanOutWidth-1:0] : '0;

endmodule

`default_nettype wire

// File: src/psgFetchArb.sv
`default_nettype none

module psgFetchArb #(
	parameter  int numChannels = 8,
	localparam int ownerWidth  = $clog2(numChannels)
) (
	input  wire logic                                              clk,
	input  wire logic                                              rst,
	input  wire logic [numChannels-1:0]                            req,
	input  wire logic [numChannels-1:0][psgPkg::waveAdrWidth-1:0]  fetchAdr,
	input  wire logic                                              ack,
	output logic      [numChannels-1:0]                            sel,
	output logic      [ownerWidth-1:0]                             seln,
	output logic                                                   rdStb,
	output logic      [psgPkg::waveAdrWidth-1:0]                   rdAdr
);

	logic                   busy;
	logic                   anyReq;
	int                     winner;
	logic [numChannels-1:0] grant;

	// lowest index wins, so scan downward and let the last hit stand
	always_comb begin
		anyReq = 1'b0;
		winner = 0;
		grant  = '0;
		for (int i = numChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				anyReq = 1'b1;
				winner = i;
			end
		end
		grant[winner] = anyReq;
	end

	// ======================================================================
	// grant and read strobe
	// ======================================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			busy  <= 1'b0;
			sel   <= '0;
			seln  <= '0;
			rdStb <= 1'b0;
		end else begin
			rdStb <= 1'b0;
			if (!busy) begin
				if (anyReq) begin
					busy  <= 1'b1;
					sel   <= grant;
					seln  <= ownerWidth'(winner);
					rdStb <= 1'b1;
				end
				// nobody asking, the last owner stays on sel and seln
			end else if (ack) begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && anyReq) begin
			rdAdr <= fetchAdr[winner];
		end
	end

endmodule

`default_nettype wire

// File: src/psgWaveTable.sv
`default_nettype none

module psgWaveTable (
	input  wire logic                              clk,
	input  wire logic                              rst,
	input  wire logic                              waveWr,
	input  wire logic [psgPkg::waveAdrWidth-1:0]   waveAdr,
	input  wire logic [psgPkg::sampleWidth-1:0]    waveData,
	input  wire logic                              rdStb,
	input  wire logic [psgPkg::waveAdrWidth-1:0]   rdAdr,
	output logic                                   ack,
	output logic      [psgPkg::sampleWidth-1:0]    rdData
);

	localparam int depth = 2 ** psgPkg::waveAdrWidth;

	logic [psgPkg::sampleWidth-1:0] mem [depth];

	// ======================================================================
	// host write port
	// ======================================================================
	always_ff @(posedge clk) begin
		if (waveWr) begin
			mem[waveAdr] <= waveData;
		end
	end

	// ======================================================================
	// fetch read port
	// ======================================================================
	// a write to the same address in the same cycle returns the old entry
	always_ff @(posedge clk) begin
		if (rdStb) begin
			rdData <= mem[rdAdr];
		end
	end

	// ack lines up with rdData one cycle after the strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			ack <= 1'b0;
		end else begin
			ack <= rdStb;
		end
	end

endmodule

`default_nettype wire

// File: src/psgMixer.sv
`default_nettype none

module psgMixer #(
	parameter int numChannels = 8
) (
	input  wire logic                                              clk,
	input  wire logic                                              rst,
	input  wire logic                                              ce,
	input  wire logic [numChannels-1:0][psgPkg::chanOutWidth-1:0]  chanOut,
	output logic      [psgPkg::audioWidth-1:0]                     audioOut,
	output logic                                                   audioValid
);

	// eight full scale channels still fit in 18 signed bits
	localparam int sumWidth = 18;
	localparam int extWidth = sumWidth - psgPkg::chanOutWidth;

	localparam logic signed [sumWidth-1:0] maxAudio = 2 ** (psgPkg::audioWidth - 1) - 1;
	localparam logic signed [sumWidth-1:0] minAudio = -(2 ** (psgPkg::audioWidth - 1));

	logic signed [sumWidth-1:0]           sum;
	logic        [psgPkg::audioWidth-1:0] clamped;

	always_comb begin
		sum = '0;
		for (int i = 0; i < numChannels; i++) begin
			sum = sum + {{extWidth{chanOut[i][psgPkg::chanOutWidth-1]}}, chanOut[i]};
		end
	end

	// ======================================================================
	// saturate to the audio word
	// ======================================================================
	always_comb begin
		if (sum > maxAudio) begin
			clamped = maxAudio[psgPkg::audioWidth-1:0];
		end else if (sum < minAudio) begin
			clamped = minAudio[psgPkg::audioWidth-1:0];
		end else begin
			clamped = sum[psgPkg::audioWidth-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			audioOut   <= '0;
			audioValid <= 1'b0;
		end else begin
			audioValid <= ce;
			if (ce) begin
				audioOut <= clamped;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/psgTop.sv
`default_nettype none

module psgTop #(
	parameter  int numChannels = 8,
	localparam int ownerWidth  = $clog2(numChannels)
) (
	input  wire logic                             clk,
	input  wire logic                             rst,
	input  wire logic                             ce,
	input  wire logic                             regWr,
	input  wire logic [psgPkg::regAdrWidth-1:0]   regAdr,
	input  wire logic [psgPkg::regDataWidth-1:0]  regData,
	output logic      [psgPkg::audioWidth-1:0]    audioOut,
	output logic                                  audioValid,
	output logic      [numChannels-1:0]           sel,
	output logic      [ownerWidth-1:0]            seln,
	output logic                                  ack
);

	logic [numChannels-1:0]                            freqWr;
	logic [numChannels-1:0]                            cfgWr;
	logic [psgPkg::phaseWidth-1:0]                     freqVal;
	logic                                              cfgEnable;
	logic [psgPkg::volWidth-1:0]                       cfgVolume;
	logic [psgPkg::waveAdrWidth-1:0]                   cfgBase;
	logic                                              waveWr;
	logic [psgPkg::waveAdrWidth-1:0]                   waveAdr;
	logic [psgPkg::sampleWidth-1:0]                    waveData;
	logic [numChannels-1:0]                            req;
	logic [numChannels-1:0][psgPkg::waveAdrWidth-1:0]  fetchAdr;
	logic [numChannels-1:0][psgPkg::chanOutWidth-1:0]  chanOut;
	logic                                              rdStb;
	logic [psgPkg::waveAdrWidth-1:0]                   rdAdr;
	logic [psgPkg::sampleWidth-1:0]                    rdData;

	// ======================================================================
	// host register path
	// ======================================================================
	psgRegDecode #(.numChannels(numChannels)) u_regDecode (
		.clk(clk), .rst(rst), .regWr(regWr), .regAdr(regAdr), .regData(regData),
		.freqWr(freqWr), .cfgWr(cfgWr), .freqVal(freqVal), .cfgEnable(cfgEnable),
		.cfgVolume(cfgVolume), .cfgBase(cfgBase),
		.waveWr(waveWr), .waveAdr(waveAdr), .waveData(waveData)
	);

	// ======================================================================
	// channels, rdData and ack are shared by all of them
	// ======================================================================
	for (genvar i = 0; i < numChannels; i++) begin : gChan
		psgWaveChannel u_chan (
			.clk(clk), .rst(rst), .ce(ce),
			.freqWr(freqWr[i]), .cfgWr(cfgWr[i]), .freqVal(freqVal),
			.cfgEnable(cfgEnable), .cfgVolume(cfgVolume), .cfgBase(cfgBase),
			.sel(sel[i]), .ack(ack), .rdData(rdData),
			.req(req[i]), .fetchAdr(fetchAdr[i]), .chanOut(chanOut[i])
		);
	end

	psgFetchArb #(.numChannels(numChannels)) u_fetchArb (
		.clk(clk), .rst(rst), .req(req), .fetchAdr(fetchAdr), .ack(ack),
		.sel(sel), .seln(seln), .rdStb(rdStb), .rdAdr(rdAdr)
	);

	psgWaveTable u_waveTable (
		.clk(clk), .rst(rst), .waveWr(waveWr), .waveAdr(waveAdr), .waveData(waveData),
		.rdStb(rdStb), .rdAdr(rdAdr), .ack(ack), .rdData(rdData)
	);

	psgMixer #(.numChannels(numChannels)) u_mixer (
		.clk(clk), .rst(rst), .ce(ce), .chanOut(chanOut),
		.audioOut(audioOut), .audioValid(audioValid)
	);

endmodule

`default_nettype wire

// File: verif/psgTb.sv
`default_nettype none

module psgTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int numChannels = 8;
	localparam int cePeriod    = 32;
	localparam int waveDepth   = 256;
	// 40 enable periods plus the bulk wave writes
	localparam int cycleLimit  = 40 * cePeriod + waveDepth + 64;

	logic        clk;
	logic        rst;
	logic        ce;
	logic        regWr;
	logic [8:0]  regAdr;
	logic [15:0] regData;
	logic [15:0] audioOut;
	logic        audioValid;
	logic [7:0]  sel;
	logic [2:0]  seln;
	logic        ack;

	// shadow state of the DUT
	logic signed [7:0] waveShadow [waveDepth];
	logic [15:0]       freqM [numChannels];
	logic              enM [numChannels];
	logic [6:0]        volM [numChannels];
	logic [7:0]        baseM [numChannels];
	logic [15:0]       phaseM [numChannels];
	logic signed [7:0] sampleM [numChannels];

	int          ownerQ[$];
	int          seed = 32'h8037ff76;
	int          errors = 0;
	int          ackCount = 0;
	int          audioCount = 0;
	int          cycles = 0;
	logic        ceStarted = 1'b0;
	logic [15:0] expAudio = '0;
	logic [15:0] lastAudio = '0;

	psgTop #(.numChannels(numChannels)) u_psgTop (
		.clk(clk), .rst(rst), .ce(ce), .regWr(regWr), .regAdr(regAdr), .regData(regData),
		.audioOut(audioOut), .audioValid(audioValid), .sel(sel), .seln(seln), .ack(ack)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ======================================================================
	// reference model
	// ======================================================================
	// clamped sum of volume times the sample from the last fetch round
	function automatic logic [15:0] mixModel();
		int sum;
		sum = 0;
		for (int ch = 0; ch < numChannels; ch++) begin
			if (enM[ch]) begin
				sum = sum + int'(sampleM[ch]) * int'(volM[ch]);
			end
		end
		if (sum > 32767) begin
			sum = 32767;
		end else if (sum < -32768) begin
			sum = -32768;
		end
		return 16'(sum);
	endfunction

	// step the phases and fetch in ascending channel order
	task automatic advanceModel();
		logic [7:0] adr;
		for (int ch = 0; ch < numChannels; ch++) begin
			if (enM[ch]) begin
				phaseM[ch] = phaseM[ch] + freqM[ch];
				adr = baseM[ch] + {2'b00, phaseM[ch][15:10]};
				sampleM[ch] = waveShadow[adr];
				ownerQ.push_back(ch);
			end
		end
	endtask

	// ======================================================================
	// stimulus tasks
	// ======================================================================
	task automatic hostWrite(input logic [8:0] adr, input logic [15:0] data);
		int ch;
		@(posedge clk);
		#1;
		regWr = 1'b1;
		regAdr = adr;
		regData = data;
		if (adr[8]) begin
			waveShadow[adr[7:0]] = data[7:0];
		end else begin
			ch = int'(adr[3:1]);
			if (adr[0]) begin
				enM[ch] = data[15];
				volM[ch] = data[14:8];
				baseM[ch] = data[7:0];
			end else begin
				freqM[ch] = data;
			end
		end
	endtask

	task automatic endWrites();
		@(posedge clk);
		#1;
		regWr = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic runPeriods(input int n);
		for (int p = 0; p < n; p++) begin
			@(posedge clk);
			#1;
			if (ownerQ.size() != 0) begin
				errors++;
				$display("fetch round incomplete at t=%0t, %0d grants missing", $time,
					ownerQ.size());
				ownerQ.delete();
			end
			expAudio = mixModel();
			advanceModel();
			ceStarted = 1'b1;
			ce = 1'b1;
			@(posedge clk);
			#1;
			ce = 1'b0;
			repeat (cePeriod - 2) @(posedge clk);
		end
	endtask

	task automatic checkAudio(input logic [15:0] expected);
		assert (lastAudio == expected) else begin
			errors++;
			$display("CHECK FAILED t=%0t audioOut expected %h got %h", $time, expected, lastAudio);
		end
	endtask

	// ======================================================================
	// checks
	// ======================================================================
	assert property (@(posedge clk) disable iff (rst) audioValid |-> audioOut == expAudio)
	else begin
		errors++;
		$display("CHECK FAILED t=%0t audioOut expected %h got %h", $time, expAudio,
			$sampled(audioOut));
	end

	// audioValid is a one cycle pulse right after each ce
	assert property (@(posedge clk) disable iff (rst) audioValid == $past(ce))
	else begin
		errors++;
		$display("CHECK FAILED t=%0t audioValid expected %b got %b", $time,
			!$sampled(audioValid), $sampled(audioValid));
	end

	assert property (@(posedge clk) disable iff (rst) (sel != '0) |-> sel == (1 << seln))
	else begin
		errors++;
		$display("CHECK FAILED t=%0t sel expected %b got %b", $time, 8'(1 << $sampled(seln)),
			$sampled(sel));
	end

	// every change of sel is a grant and is followed by its ack
	assert property (@(posedge clk) disable iff (rst) !$stable(sel) |=> ack)
	else begin
		errors++;
		$display("sel changed at t=%0t without an ack on the following cycle", $time);
	end

	always @(posedge clk) begin : idleCheck
		if (!rst && !ceStarted) begin
			assert (!audioValid && audioOut == '0 && sel == '0 && seln == '0 && !ack) else begin
				errors++;
				$display("CHECK FAILED t=%0t idle outputs expected all 0", $time,
					" got audioValid=%b audioOut=%h", audioValid, audioOut,
					" sel=%b seln=%0d ack=%b", sel, seln, ack);
			end
		end
	end

	always @(posedge clk) begin : ackCheck
		int expOwner;
		if (!rst && ack) begin
			ackCount++;
			if (ownerQ.size() == 0) begin
				errors++;
				$display("ack at t=%0t with no fetch outstanding", $time);
			end else begin
				expOwner = ownerQ.pop_front();
				assert (seln == 3'(expOwner)) else begin
					errors++;
					$display("CHECK FAILED t=%0t seln expected %0d got %0d", $time, expOwner, seln);
				end
			end
		end
	end

	always @(posedge clk) begin
		if (audioValid) begin
			audioCount++;
			lastAudio <= audioOut;
		end
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("Regression failed");
			$finish;
		end
	end

	// ======================================================================
	// test sequence
	// ======================================================================
	initial begin
		rst = 1'b1;
		ce = 1'b0;
		regWr = 1'b0;
		regAdr = '0;
		regData = '0;
		for (int ch = 0; ch < numChannels; ch++) begin
			freqM[ch] = '0;
			enM[ch] = 1'b0;
			volM[ch] = '0;
			baseM[ch] = '0;
			phaseM[ch] = '0;
			sampleM[ch] = '0;
		end
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		// random wave with channels 2 and 5 left disabled
		for (int a = 0; a < waveDepth; a++) begin
			hostWrite({1'b1, 8'(a)}, {8'h00, 8'($random(seed))});
		end
		for (int ch = 0; ch < numChannels; ch++) begin
			hostWrite({5'b0, 3'(ch), 1'b0}, {4'h0, 12'($random(seed))} | 16'h0040);
			hostWrite({5'b0, 3'(ch), 1'b1},
				{ch != 2 && ch != 5, 7'($random(seed)), 8'($random(seed))});
		end
		endWrites();
		runPeriods(12);

		// register update between two ce pulses
		hostWrite(9'h000, {4'h0, 12'($random(seed))} | 16'h0200);
		hostWrite(9'h007, {1'b0, 7'($random(seed)), 8'($random(seed))});
		hostWrite(9'h00b, {1'b1, 7'($random(seed)), 8'($random(seed))});
		hostWrite(9'h00d, {1'b1, 7'h7f, baseM[6]});
		endWrites();
		runPeriods(8);

		// saturate high and then low
		for (int ch = 0; ch < numChannels; ch++) begin
			hostWrite({5'b0, 3'(ch), 1'b1}, {1'b1, 7'h7f, 8'h00});
		end
		for (int a = 0; a < 64; a++) begin
			hostWrite({1'b1, 8'(a)}, 16'h007f);
		end
		endWrites();
		runPeriods(3);
		checkAudio(16'h7fff);
		for (int a = 0; a < 64; a++) begin
			hostWrite({1'b1, 8'(a)}, 16'h0080);
		end
		endWrites();
		runPeriods(3);
		checkAudio(16'h8000);

		if (ownerQ.size() != 0) begin
			errors++;
			$display("last fetch round incomplete, %0d grants missing", ownerQ.size());
		end
		$display("summary: %0d errors, %0d acks, %0d audio words, %0d cycles",
			errors, ackCount, audioCount, cycles);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
src/psgPkg.sv
src/psgRegDecode.sv
src/psgWaveChannel.sv
src/psgFetchArb.sv
src/psgWaveTable.sv
src/psgMixer.sv
src/psgTop.sv
verif/psgTb.sv
